//--- vlog.f
src/adc_readout_pkg.sv
src/sample_if.sv
src/drp_reader.sv
src/code_scaler.sv
src/bin2bcd_pipe.sv
src/adc_readout_top.sv
tb/tb_adc_readout.sv

//--- Makefile
# Verilator build and run of the adc readout testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_readout
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/10ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/10ps -Wall
PASS_LINE ?= Simulation PASSED

SRCS := $(wildcard src/*.sv tb/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_adc_readout.sv
`timescale 1ns/10ps

module tb_adc_readout;

    // same values as the top level defaults
    localparam logic [6:0]  ch_a_addr  = 7'h03;
    localparam logic [6:0]  ch_b_addr  = 7'h16;
    localparam logic [11:0] alarm_code = 12'he00;
    // millivolts over the 1 V span
    localparam int unsigned mv_span    = 1000;
    // drp_drdy to dout_valid, in cycles
    localparam int          pipe_lat   = 12;
    localparam int          n_samples  = 80;

    // one adc reply as the model sent it
    typedef struct packed {
        logic [11:0] code;
        logic        chan;
        logic [31:0] cyc;
    } reply_t;

    logic        clk;
    logic        arst_n;
    logic        eoc;
    logic        drp_den;
    logic [6:0]  drp_addr;
    logic        drp_drdy;
    logic [15:0] drp_do;
    logic        dout_valid;
    logic        dout_chan;
    logic [15:0] dout;
    logic        alarm;

    // reference read port state
    logic        rd_open;
    logic        next_chan;
    logic [6:0]  exp_addr;
    // oldest reply, loaded in the cycle its result comes out
    logic [15:0] head_bcd;
    logic        head_chan;
    logic        head_alarm;
    int          head_lat;
    logic        seen_result;
    logic        rst_check;

    reply_t      exp_q[$];
    logic [31:0] lfsr_state;
    int          cycle_no;
    int          reply_wait;
    int          eoc_gap;
    int          n_sent;
    int          n_checked;
    int          errors;
    int          timeouts;
    int          guard;

    adc_readout_top #(
        .CH_A_ADDR  (ch_a_addr),
        .CH_B_ADDR  (ch_b_addr),
        .ALARM_CODE (alarm_code)
    ) adc_readout_top_i (.*);

    // 40 ns period
    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////

    // busy from the issuing eoc until the reply, channel flips per reply
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_open   <= 1'b0;
            next_chan <= 1'b0;
        end else if (drp_drdy) begin
            rd_open   <= 1'b0;
            next_chan <= ~next_chan;
        end else if (eoc) begin
            rd_open   <= 1'b1;
        end
    end

    assign exp_addr = next_chan ? ch_b_addr : ch_a_addr;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        int          i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | 32'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // millivolts = code * 1000 >> 12, then decimal digits
    function automatic logic [15:0] expected_digits(input logic [11:0] code);
        int unsigned mv;
        mv = (32'(code) * mv_span) >> 12;
        return {4'(mv / 1000), 4'(mv / 100 % 10), 4'(mv / 10 % 10), 4'(mv % 10)};
    endfunction

    // boundary codes first, then a mix of boundary and random
    function automatic logic [11:0] pick_code();
        logic [3:0] sel;
        sel = (n_sent < 4) ? 4'(n_sent) : 4'(take_bits(4));
        case (sel)
            4'd0:    return 12'd0;
            4'd1:    return 12'd4095;
            4'd2:    return alarm_code;
            4'd3:    return alarm_code + 12'd1;
            default: return 12'(take_bits(12));
        endcase
    endfunction

    task automatic count_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    //////////////////////////////////////////////////
    // per cycle stimulus, adc model, scoreboard
    //////////////////////////////////////////////////

    task automatic step_cycle(input logic gen_eoc);
        reply_t rec;
        @(posedge clk);
        #2;
        cycle_no++;
        eoc      = 1'b0;
        drp_drdy = 1'b0;
        // result leaving the DUT this cycle
        if (dout_valid) begin
            if (exp_q.size() == 0) begin
                count_error($sformatf("dout_valid at t=%0t with no reply outstanding", $time));
            end else begin
                rec         = exp_q.pop_front();
                head_bcd    = expected_digits(rec.code);
                head_chan   = rec.chan;
                head_alarm  = rec.code > alarm_code;
                head_lat    = cycle_no - int'(rec.cyc);
                seen_result = 1'b1;
                n_checked++;
            end
        end
        // adc answers 1 to 6 cycles after the request
        if (reply_wait > 0) begin
            reply_wait--;
            if (reply_wait == 0) begin
                rec.code = pick_code();
                rec.chan = next_chan;
                rec.cyc  = 32'(cycle_no);
                exp_q.push_back(rec);
                drp_drdy = 1'b1;
                // low nibble is not part of the result
                drp_do   = {rec.code, 4'(take_bits(4))};
                n_sent++;
            end
        end
        if (drp_den) begin
            reply_wait = 1 + int'(take_bits(3) % 6);
        end
        // gap 0 gives eoc on back-to-back cycles
        if (gen_eoc) begin
            if (eoc_gap == 0) begin
                eoc     = 1'b1;
                eoc_gap = int'(take_bits(4));
            end else begin
                eoc_gap--;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_den_on_eoc: assert property (@(posedge clk) disable iff (!arst_n)
        (eoc && !rd_open) |=> drp_den)
        else count_error($sformatf("t=%0t drp_den missing after an eoc at idle", $time));

    // so also never a second request before drp_drdy
    a_den_only_on_eoc: assert property (@(posedge clk) disable iff (!arst_n)
        drp_den |-> $past(eoc && !rd_open))
        else count_error($sformatf("t=%0t drp_den without an eoc at idle", $time));

    a_addr: assert property (@(posedge clk) disable iff (!arst_n)
        drp_den |-> drp_addr == exp_addr)
        else count_error($sformatf("FAILED t=%0t drp_addr: got %h expected %h",
            $time, $sampled(drp_addr), $sampled(exp_addr)));

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid == $past(drp_drdy, pipe_lat))
        else count_error($sformatf("FAILED t=%0t dout_valid: got %b expected %b",
            $time, $sampled(dout_valid), !$sampled(dout_valid)));

    // results leave in reply order
    a_order: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid |-> head_lat == pipe_lat)
        else count_error($sformatf("FAILED t=%0t dout_valid latency: got %0d expected %0d",
            $time, $sampled(head_lat), pipe_lat));

    a_value: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid |-> dout == head_bcd)
        else count_error($sformatf("FAILED t=%0t dout: got %h expected %h",
            $time, $sampled(dout), $sampled(head_bcd)));

    a_chan: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid |-> dout_chan == head_chan)
        else count_error($sformatf("FAILED t=%0t dout_chan: got %b expected %b",
            $time, $sampled(dout_chan), $sampled(head_chan)));

    a_alarm: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid |-> alarm == head_alarm)
        else count_error($sformatf("FAILED t=%0t alarm: got %b expected %b",
            $time, $sampled(alarm), $sampled(head_alarm)));

    a_alarm_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !dout_valid |-> $stable(alarm))
        else count_error($sformatf("t=%0t alarm changed without dout_valid", $time));

    a_reset_quiet: assert property (@(posedge clk)
        (rst_check && !arst_n) |-> (!drp_den && !dout_valid && !alarm && dout == 16'h0000))
        else count_error($sformatf("t=%0t outputs not idle during reset", $time));

    a_idle_start: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_result |-> (!alarm && dout == 16'h0000))
        else count_error($sformatf("t=%0t alarm or dout set before the first result", $time));

    //////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        eoc         = 1'b0;
        drp_drdy    = 1'b0;
        drp_do      = 16'h0000;
        lfsr_state  = 32'hf71b8dfb;
        head_bcd    = 16'h0000;
        head_chan   = 1'b0;
        head_alarm  = 1'b0;
        head_lat    = 0;
        seen_result = 1'b0;
        rst_check   = 1'b0;
        cycle_no    = 0;
        reply_wait  = 0;
        eoc_gap     = 0;
        n_sent      = 0;
        n_checked   = 0;
        errors      = 0;
        timeouts    = 0;
        // reset held 16 cycles, checked from the second edge on
        repeat (16) begin
            @(posedge clk);
            rst_check = 1'b1;
        end
        #2;
        arst_n = 1'b1;
        for (guard = 0; guard < 40 * n_samples && n_sent < n_samples; guard++) begin
            step_cycle(1'b1);
        end
        if (n_sent < n_samples) begin
            timeouts++;
            $display("timeout: only %0d of %0d replies sent", n_sent, n_samples);
        end else begin
            // eoc stops, open read and pipeline drain
            for (guard = 0; guard < 100 && (reply_wait != 0 || rd_open || exp_q.size() != 0);
                 guard++) begin
                step_cycle(1'b0);
            end
            if (reply_wait != 0 || rd_open || exp_q.size() != 0) begin
                timeouts++;
                $display("timeout: %0d results never came out", exp_q.size());
            end
            // one more edge so the checks see the last result
            step_cycle(1'b0);
        end
        $display("replies %0d, results checked %0d, errors %0d, timeouts %0d",
                 n_sent, n_checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- src/adc_readout_top.sv
`timescale 1ns/10ps

module adc_readout_top #(
    parameter logic [adc_readout_pkg::drp_addr_w-1:0] CH_A_ADDR  = 7'h03,
    parameter logic [adc_readout_pkg::drp_addr_w-1:0] CH_B_ADDR  = 7'h16,
    parameter logic [adc_readout_pkg::code_w-1:0]     ALARM_CODE = 12'he00
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    // system monitor read port
    input  logic                                     eoc,
    output logic                                     drp_den,
    output logic [adc_readout_pkg::drp_addr_w-1:0]   drp_addr,
    input  logic                                     drp_drdy,
    input  logic [15:0]                              drp_do,
    // decimal readout
    output logic                                     dout_valid,
    output logic                                     dout_chan,
    output logic [4*adc_readout_pkg::bcd_digits-1:0] dout,
    output logic                                     alarm
);

    //////////////////////////////////////////////////
    // stage links
    //////////////////////////////////////////////////

    // raw codes, reader to scaler
    sample_if #(.WIDTH(adc_readout_pkg::code_w)) code_bus ();
    // millivolts, scaler to bcd converter
    sample_if #(.WIDTH(adc_readout_pkg::mv_w))   mv_bus ();

    //////////////////////////////////////////////////
    // pipeline, 12 cycles from drdy to dout_valid
    //////////////////////////////////////////////////

    drp_reader #(
        .CH_A_ADDR  (CH_A_ADDR),
        .CH_B_ADDR  (CH_B_ADDR),
        .ALARM_CODE (ALARM_CODE)
    ) drp_reader_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .eoc      (eoc),
        .drp_den  (drp_den),
        .drp_addr (drp_addr),
        .drp_drdy (drp_drdy),
        .drp_do   (drp_do),
        .code_bus (code_bus.source)
    );

    code_scaler code_scaler_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .code_bus (code_bus.sink),
        .mv_bus   (mv_bus.source)
    );

    // digits, tag and alarm go straight out
    bin2bcd_pipe bin2bcd_pipe_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mv_bus    (mv_bus.sink),
        .out_valid (dout_valid),
        .out_chan  (dout_chan),
        .out_ovr   (alarm),
        .out_bcd   (dout)
    );

endmodule

//--- src/bin2bcd_pipe.sv
`timescale 1ns/10ps

module bin2bcd_pipe (
    input  logic                                     clk,
    input  logic                                     arst_n,
    sample_if.sink                                   mv_bus,
    output logic                                     out_valid,
    output adc_readout_pkg::chan_t                   out_chan,
    output logic                                     out_ovr,
    output logic [4*adc_readout_pkg::bcd_digits-1:0] out_bcd
);

    // one stage per binary input bit
    localparam int n_bits = adc_readout_pkg::mv_w;
    localparam int bcd_w  = 4 * adc_readout_pkg::bcd_digits;

    //////////////////////////////////////////////////
    // shift-and-add-3 stages
    //////////////////////////////////////////////////

    for (genvar s = 0; s < n_bits; s++) begin : g_stage
        // stage inputs
        logic                   in_vld;
        adc_readout_pkg::chan_t in_chan;
        logic                   in_ovr;
        logic [bcd_w-1:0]       in_bcd;
        logic [n_bits-1:0]      in_bin;
        // digits after the add-3 correction
        logic [bcd_w-1:0]       adj;
        // stage registers
        logic                   vld_q;
        adc_readout_pkg::chan_t chan_q;
        logic                   ovr_q;
        logic [bcd_w-1:0]       bcd_q;
        logic [n_bits-1:0]      bin_q;

        if (s == 0) begin : g_head
            // first stage starts from an empty bcd register
            assign in_vld  = mv_bus.valid;
            assign in_chan = mv_bus.chan;
            assign in_ovr  = mv_bus.ovr;
            assign in_bcd  = '0;
            assign in_bin  = mv_bus.value;
        end else begin : g_link
            assign in_vld  = g_stage[s-1].vld_q;
            assign in_chan = g_stage[s-1].chan_q;
            assign in_ovr  = g_stage[s-1].ovr_q;
            assign in_bcd  = g_stage[s-1].bcd_q;
            assign in_bin  = g_stage[s-1].bin_q;
        end

        // nibbles of 5 or more get 3 added before the shift
        always_comb begin
            adj = in_bcd;
            for (int d = 0; d < adc_readout_pkg::bcd_digits; d++) begin
                if (adj[4*d +: 4] >= 4'd5) begin
                    adj[4*d +: 4] = adj[4*d +: 4] + 4'd3;
                end
            end
        end

        // loads only on a sample, so the last stage holds the readout
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                vld_q  <= 1'b0;
                chan_q <= adc_readout_pkg::chan_a;
                ovr_q  <= 1'b0;
                bcd_q  <= '0;
                bin_q  <= '0;
            end else begin
                vld_q <= in_vld;
                if (in_vld) begin
                    chan_q <= in_chan;
                    ovr_q  <= in_ovr;
                    // msb of the binary word moves into the bcd lsb
                    bcd_q  <= {adj[bcd_w-2:0], in_bin[n_bits-1]};
                    bin_q  <= in_bin << 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign out_valid = g_stage[n_bits-1].vld_q;
    assign out_chan  = g_stage[n_bits-1].chan_q;
    assign out_ovr   = g_stage[n_bits-1].ovr_q;
    assign out_bcd   = g_stage[n_bits-1].bcd_q;

    // each finished digit is decimal
    for (genvar d = 0; d < adc_readout_pkg::bcd_digits; d++) begin : g_digit_chk
        a_digit_range: assert property (
            @(posedge clk) disable iff (!arst_n)
            out_valid |-> (out_bcd[4*d +: 4] <= 4'd9)
        );
    end

endmodule

//--- src/code_scaler.sv
`timescale 1ns/10ps

module code_scaler (
    input  logic     clk,
    input  logic     arst_n,
    sample_if.sink   code_bus,
    sample_if.source mv_bus
);

    // full product width, 4095 * 1000 fits in 22 bits
    localparam int prod_w = adc_readout_pkg::code_w + adc_readout_pkg::mv_w;

    //////////////////////////////////////////////////
    // code to millivolts
    //////////////////////////////////////////////////

    // code * 1000
    logic [prod_w-1:0] product;

    always_comb begin
        product = prod_w'(code_bus.value) * prod_w'(adc_readout_pkg::full_scale_mv);
    end

    // strobe, one register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mv_bus.valid <= 1'b0;
        end else begin
            mv_bus.valid <= code_bus.valid;
        end
    end

    // divide by 2**code_w, keep the integer part
    // tag and flag ride along in the same stage
    always_ff @(posedge clk) begin
        if (code_bus.valid) begin
            mv_bus.value <= product[adc_readout_pkg::code_w +: adc_readout_pkg::mv_w];
            mv_bus.chan  <= code_bus.chan;
            mv_bus.ovr   <= code_bus.ovr;
        end
    end

    //////////////////////////////////////////////////
    // range check
    //////////////////////////////////////////////////

    // truncation keeps the result below full scale, 999 at most
    a_mv_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        mv_bus.valid |->
            mv_bus.value < adc_readout_pkg::mv_w'(adc_readout_pkg::full_scale_mv)
    );

endmodule

//--- src/drp_reader.sv
`timescale 1ns/10ps

module drp_reader #(
    parameter logic [adc_readout_pkg::drp_addr_w-1:0] CH_A_ADDR  = 7'h03,
    parameter logic [adc_readout_pkg::drp_addr_w-1:0] CH_B_ADDR  = 7'h16,
    parameter logic [adc_readout_pkg::code_w-1:0]     ALARM_CODE = 12'he00
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   eoc,
    output logic                                   drp_den,
    output logic [adc_readout_pkg::drp_addr_w-1:0] drp_addr,
    input  logic                                   drp_drdy,
    input  logic [15:0]                            drp_do,
    sample_if.source                               code_bus
);

    //////////////////////////////////////////////////
    // read request control
    //////////////////////////////////////////////////

    // high from the request until the reply
    logic                               busy;
    // channel of the read in flight, or of the next read when idle
    adc_readout_pkg::chan_t             chan_sel;
    // eoc that finds the port idle
    logic                               issue;
    // reply is only taken while a read is open
    logic                               reply;
    // 12-bit result, left-justified in the read word
    logic [adc_readout_pkg::code_w-1:0] code;

    assign issue = eoc && !busy;
    assign reply = drp_drdy && busy;
    assign code  = drp_do[15 -: adc_readout_pkg::code_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            chan_sel <= adc_readout_pkg::chan_a;
            drp_den  <= 1'b0;
            drp_addr <= CH_A_ADDR;
        end else begin
            // request goes out one cycle after eoc
            drp_den <= issue;
            if (issue) begin
                busy     <= 1'b1;
                drp_addr <= (chan_sel == adc_readout_pkg::chan_a) ? CH_A_ADDR : CH_B_ADDR;
            end else if (reply) begin
                busy <= 1'b0;
            end
            // switch channels only once the read has completed
            if (reply) begin
                chan_sel <= (chan_sel == adc_readout_pkg::chan_a) ?
                            adc_readout_pkg::chan_b : adc_readout_pkg::chan_a;
            end
        end
    end

    //////////////////////////////////////////////////
    // result capture
    //////////////////////////////////////////////////

    // strobe one cycle after the reply
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            code_bus.valid <= 1'b0;
        end else begin
            code_bus.valid <= reply;
        end
    end

    // payload held between results
    always_ff @(posedge clk) begin
        if (reply) begin
            code_bus.value <= code;
            code_bus.chan  <= chan_sel;
            // strictly above the threshold
            code_bus.ovr   <= (code > ALARM_CODE);
        end
    end

    //////////////////////////////////////////////////
    // read port protocol
    //////////////////////////////////////////////////

    // a reply from the adc always answers an open request
    a_drdy_outstanding: assert property (
        @(posedge clk) disable iff (!arst_n)
        drp_drdy |-> busy
    );

    // an open read stays open until its reply and blocks new requests
    a_den_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (busy && !drp_drdy) |=> (busy && !drp_den)
    );

endmodule

//--- src/sample_if.sv
`timescale 1ns/10ps

interface sample_if #(
    parameter int WIDTH = adc_readout_pkg::code_w
);

    // single-cycle strobe, no back-pressure
    logic                   valid;

    // which input the sample came from
    adc_readout_pkg::chan_t chan;

    // sample value, only meaningful with valid
    logic [WIDTH-1:0]       value;

    // code above the alarm threshold
    logic                   ovr;

    // producing stage
    modport source (
        output valid,
        output chan,
        output value,
        output ovr
    );

    // consuming stage, must take every strobe
    modport sink (
        input valid,
        input chan,
        input value,
        input ovr
    );

endinterface

//--- src/adc_readout_pkg.sv
package adc_readout_pkg;

    //////////////////////////////////////////////////
    // converter and read port widths
    //////////////////////////////////////////////////

    // adc result code, upper bits of the 16-bit read word
    localparam int code_w = 12;

    // millivolt value, 0 to 999 over a 1 V span
    localparam int mv_w = 10;

    // decimal digits on the readout, one nibble each
    localparam int bcd_digits = 4;

    // read port address width
    localparam int drp_addr_w = 7;

    //////////////////////////////////////////////////
    // scaling
    //////////////////////////////////////////////////

    // numerator of the code to millivolt ratio
    // the denominator is 2**code_w, done as a shift
    localparam int unsigned full_scale_mv = 1000;

    //////////////////////////////////////////////////
    // channel tag
    //////////////////////////////////////////////////

    // one bit is enough for the two monitored inputs
    typedef logic chan_t;

    // channel a, on-chip input pair
    localparam chan_t chan_a = 1'b0;

    // channel b, auxiliary pair
    localparam chan_t chan_b = 1'b1;

endpackage
